// File: mcpu_cfg.svh
`ifndef MCPU_CFG_SVH
`define MCPU_CFG_SVH

// Micro-address register width
`define MCPU_UADDR_W 5

// Rows in the microcode table
`define MCPU_UCODE_DEPTH 24

`define MCPU_SP_RESET 8'hff

// High address byte of the stack
`define MCPU_STACK_PAGE 8'h01

`endif

// File: uop_pkg.sv
package uop_pkg;

	typedef enum logic [7:0] {
		OP_PHP     = 8'h08,
		OP_CLC     = 8'h18,
		OP_SEC     = 8'h38,
		OP_JMP_ABS = 8'h4c,
		OP_ADC_IMM = 8'h69,
		OP_STA_ZP  = 8'h85,
		OP_LDA_IMM = 8'ha9,
		OP_SBC_IMM = 8'he9,
		OP_NOP     = 8'hea	// Also taken by unknown opcodes
	} opcode_t;

	typedef enum logic [1:0] {
		ALU_ADD  = 2'h0,
		ALU_SUB  = 2'h1,	// Add with inverted operand
		ALU_PASS = 2'h2
	} alu_op_t;

	typedef enum logic [2:0] {
		DB_DL  = 3'h0,
		DB_A   = 3'h1,
		DB_PCL = 3'h2,
		DB_PCH = 3'h3,
		DB_P   = 3'h4,
		DB_ALU = 3'h5
	} db_sel_t;

	typedef enum logic [1:0] {
		AD_PC    = 2'h0,
		AD_ZP    = 2'h1,
		AD_STACK = 2'h2,
		AD_ABS   = 2'h3
	} ad_sel_t;

	typedef enum logic [1:0] {PC_HOLD = 2'h0, PC_INC = 2'h1, PC_LOAD = 2'h2} pc_op_t;

	typedef enum logic {SEQ_NEXT = 1'b0, SEQ_DISP = 1'b1} seq_t;

endpackage

// File: flag_pkg.sv
package flag_pkg;

	// Bit positions inside P
	typedef enum int {
		FLAG_C = 0,
		FLAG_Z = 1,
		FLAG_I = 2,
		FLAG_D = 3,
		FLAG_B = 4,
		FLAG_R = 5,
		FLAG_V = 6,
		FLAG_N = 7
	} flag_bit_t;

	typedef enum logic [2:0] {
		FU_NONE = 3'h0,
		FU_NZ   = 3'h1,
		FU_NVZC = 3'h2,
		FU_SETC = 3'h3,
		FU_CLRC = 3'h4
	} flag_upd_t;

endpackage

// File: uop_sequencer.sv
`timescale 1ns/100ps
`include "mcpu_cfg.svh"

module uop_sequencer (
	input logic clk,
	input logic n_reset,
	input logic [7:0] dl,
	output uop_pkg::alu_op_t alu_op,
	output uop_pkg::db_sel_t db_sel,
	output uop_pkg::ad_sel_t ad_sel,
	output uop_pkg::pc_op_t pc_op,
	output logic a_load,
	output logic sp_dec,
	output flag_pkg::flag_upd_t flag_upd,
	output logic ab_load,
	output logic wr
);

localparam int W = `MCPU_UADDR_W;

// Entry rows and the rows that follow them
localparam logic [W-1:0] R_FETCH = W'(0);
localparam logic [W-1:0] R_LDA = W'(1);
localparam logic [W-1:0] R_ADC = W'(3);
localparam logic [W-1:0] R_SBC = W'(5);
localparam logic [W-1:0] R_SEC = W'(7);
localparam logic [W-1:0] R_CLC = W'(9);
localparam logic [W-1:0] R_PHP = W'(11);
localparam logic [W-1:0] R_JMP = W'(14);
localparam logic [W-1:0] R_STA = W'(17);
localparam logic [W-1:0] R_NOP = W'(20);

logic [W-1:0] uaddr_q, uaddr, entry;
logic disp_q;
uop_pkg::seq_t seq;

// Opcode dispatch from the byte read in the fetch cycle
always_comb
	case (dl)
	uop_pkg::OP_LDA_IMM:	entry = R_LDA;
	uop_pkg::OP_ADC_IMM:	entry = R_ADC;
	uop_pkg::OP_SBC_IMM:	entry = R_SBC;
	uop_pkg::OP_SEC:	entry = R_SEC;
	uop_pkg::OP_CLC:	entry = R_CLC;
	uop_pkg::OP_PHP:	entry = R_PHP;
	uop_pkg::OP_JMP_ABS:	entry = R_JMP;
	uop_pkg::OP_STA_ZP:	entry = R_STA;
	default:	entry = R_NOP;
	endcase

assign uaddr = disp_q ? entry : uaddr_q;	// Row after a dispatch row comes from the opcode

always_ff @(posedge clk, negedge n_reset)
	if (~n_reset) begin
		uaddr_q <= R_FETCH;
		disp_q <= 1'b0;
	end else begin
		uaddr_q <= uaddr + W'(1);
		disp_q <= seq == uop_pkg::SEQ_DISP;
	end

// Microcode table
always_comb begin
	alu_op = uop_pkg::ALU_PASS;
	db_sel = uop_pkg::DB_DL;
	ad_sel = uop_pkg::AD_PC;
	pc_op = uop_pkg::PC_INC;
	a_load = 1'b0;
	sp_dec = 1'b0;
	flag_upd = flag_pkg::FU_NONE;
	ab_load = 1'b1;
	wr = 1'b0;
	seq = uop_pkg::SEQ_DISP;	// Default row is a plain opcode fetch
	case (uaddr)
	5'd1, 5'd3, 5'd5, 5'd14:	seq = uop_pkg::SEQ_NEXT;	// Operand read
	5'd2: begin
		a_load = 1'b1;	// LDA
		flag_upd = flag_pkg::FU_NZ;
	end
	5'd4, 5'd6: begin
		alu_op = (uaddr == 5'd4) ? uop_pkg::ALU_ADD : uop_pkg::ALU_SUB;
		db_sel = uop_pkg::DB_ALU;
		a_load = 1'b1;
		flag_upd = flag_pkg::FU_NVZC;
	end
	5'd7, 5'd9, 5'd20: begin
		pc_op = uop_pkg::PC_HOLD;	// Dummy read that keeps the address on the next opcode
		ab_load = 1'b0;
		seq = uop_pkg::SEQ_NEXT;
	end
	5'd8:	flag_upd = flag_pkg::FU_SETC;
	5'd10:	flag_upd = flag_pkg::FU_CLRC;
	5'd11: begin
		db_sel = uop_pkg::DB_P;
		ad_sel = uop_pkg::AD_STACK;
		pc_op = uop_pkg::PC_HOLD;
		sp_dec = 1'b1;
		wr = 1'b1;
		seq = uop_pkg::SEQ_NEXT;
	end
	5'd12: begin
		pc_op = uop_pkg::PC_HOLD;	// Back to the PC after the push
		seq = uop_pkg::SEQ_NEXT;
	end
	5'd15: begin
		ad_sel = uop_pkg::AD_ABS;
		pc_op = uop_pkg::PC_LOAD;
		seq = uop_pkg::SEQ_NEXT;
	end
	5'd17: begin
		db_sel = uop_pkg::DB_A;
		ad_sel = uop_pkg::AD_ZP;
		pc_op = uop_pkg::PC_HOLD;
		wr = 1'b1;
		seq = uop_pkg::SEQ_NEXT;
	end
	5'd18:	seq = uop_pkg::SEQ_NEXT;	// Back to the PC after the store
	default: ;
	endcase
end

assert property (@(posedge clk) disable iff (!n_reset) uaddr < `MCPU_UCODE_DEPTH);
assert property (@(posedge clk) disable iff (!n_reset) seq == uop_pkg::SEQ_DISP |-> !wr);

endmodule

// File: cpu_datapath.sv
`timescale 1ns/100ps
`include "mcpu_cfg.svh"

module cpu_datapath (
	input logic clk,
	input logic n_reset,
	input logic [7:0] data_in,
	input uop_pkg::alu_op_t alu_op,
	input uop_pkg::db_sel_t db_sel,
	input uop_pkg::ad_sel_t ad_sel,
	input uop_pkg::pc_op_t pc_op,
	input logic a_load,
	input logic sp_dec,
	input logic carry_in,
	input logic [7:0] p,
	output logic [7:0] dl,
	output logic [15:0] ad_bus,
	output logic [7:0] db_bus,
	output logic [7:0] alu_res,
	output logic alu_carry,
	output logic alu_ovf
);

logic [7:0] a, sp;
logic [15:0] pc;
logic [7:0] b_in;
logic [8:0] sum;

always_ff @(posedge clk)
	dl <= data_in;

// Data bus
always_comb
	case (db_sel)
	uop_pkg::DB_DL:	db_bus = dl;
	uop_pkg::DB_A:	db_bus = a;
	uop_pkg::DB_PCL:	db_bus = pc[7:0];
	uop_pkg::DB_PCH:	db_bus = pc[15:8];
	uop_pkg::DB_P:	db_bus = p | 8'h30;	// Pushed with R and B set
	uop_pkg::DB_ALU:	db_bus = alu_res;
	default:	db_bus = dl;
	endcase

// Address bus; the newest operand byte is still on data_in, the older one sits in dl
always_comb
	case (ad_sel)
	uop_pkg::AD_PC:	ad_bus = pc + ((pc_op == uop_pkg::PC_INC) ? 16'd1 : 16'd0);
	uop_pkg::AD_ZP:	ad_bus = {8'h00, data_in};
	uop_pkg::AD_STACK:	ad_bus = {`MCPU_STACK_PAGE, sp};
	uop_pkg::AD_ABS:	ad_bus = {data_in, dl};	// High byte live, low byte held
	default:	ad_bus = pc;
	endcase

// ALU
assign b_in = (alu_op == uop_pkg::ALU_SUB) ? ~dl : dl;
assign sum = {1'b0, a} + {1'b0, b_in} + {8'h00, carry_in};

always_comb
	if (alu_op == uop_pkg::ALU_PASS) begin
		alu_res = dl;	// Operand passes for LDA flags
		alu_carry = 1'b0;
		alu_ovf = 1'b0;
	end else begin
		alu_res = sum[7:0];
		alu_carry = sum[8];
		alu_ovf = (a[7] == b_in[7]) && (sum[7] != a[7]);
	end

always_ff @(posedge clk, negedge n_reset)
	if (~n_reset) begin
		a <= 8'h00;
		sp <= `MCPU_SP_RESET;
		pc <= 16'h0000;
	end else begin
		if (a_load)
			a <= db_bus;
		if (sp_dec)
			sp <= sp - 8'd1;
		case (pc_op)
		uop_pkg::PC_INC:	pc <= pc + 16'd1;
		uop_pkg::PC_LOAD:	pc <= ad_bus;
		default: ;
		endcase
	end

assert property (@(posedge clk) disable iff (!n_reset)
	a_load |-> (db_sel == uop_pkg::DB_ALU || db_sel == uop_pkg::DB_DL));

endmodule

// File: status_unit.sv
`timescale 1ns/100ps

module status_unit (
	input logic clk,
	input logic n_reset,
	input flag_pkg::flag_upd_t flag_upd,
	input logic [7:0] alu_res,
	input logic alu_carry,
	input logic alu_ovf,
	output logic [7:0] p,
	output logic carry_in
);

logic [7:0] mask, pn;

// Candidate flags from the ALU
always_comb begin
	pn = p;
	pn[flag_pkg::FLAG_N] = alu_res[7];
	pn[flag_pkg::FLAG_V] = alu_ovf;
	pn[flag_pkg::FLAG_Z] = alu_res == 8'h00;
	pn[flag_pkg::FLAG_C] = alu_carry;
	if (flag_upd == flag_pkg::FU_SETC)
		pn[flag_pkg::FLAG_C] = 1'b1;
	else if (flag_upd == flag_pkg::FU_CLRC)
		pn[flag_pkg::FLAG_C] = 1'b0;
end

always_comb begin
	mask = 8'h00;
	case (flag_upd)
	flag_pkg::FU_NZ: begin
		mask[flag_pkg::FLAG_N] = 1'b1;
		mask[flag_pkg::FLAG_Z] = 1'b1;
	end
	flag_pkg::FU_NVZC: begin
		mask[flag_pkg::FLAG_N] = 1'b1;
		mask[flag_pkg::FLAG_V] = 1'b1;
		mask[flag_pkg::FLAG_Z] = 1'b1;
		mask[flag_pkg::FLAG_C] = 1'b1;
	end
	flag_pkg::FU_SETC, flag_pkg::FU_CLRC:	mask[flag_pkg::FLAG_C] = 1'b1;
	default: ;
	endcase
end

always_ff @(posedge clk, negedge n_reset)
	if (~n_reset)
		p <= 8'h20;	// Only R
	else
		p <= (p & ~mask) | (pn & mask);

assign carry_in = p[flag_pkg::FLAG_C];

assert property (@(posedge clk) disable iff (!n_reset) p[flag_pkg::FLAG_R]);

endmodule

// File: bus_interface.sv
`timescale 1ns/100ps

module bus_interface (
	input logic clk,
	input logic n_reset,
	input logic ab_load,
	input logic wr,
	input logic [15:0] ad_bus,
	input logic [7:0] db_bus,
	output logic [15:0] addr,
	output logic rw,
	output logic [7:0] data_out
);

always_ff @(posedge clk, negedge n_reset)
	if (~n_reset)
		addr <= 16'h0000;
	else if (ab_load)
		addr <= ad_bus;

always_ff @(posedge clk, negedge n_reset)
	if (~n_reset) begin
		rw <= 1'b1;
		data_out <= 8'h00;
	end else begin
		rw <= ~wr;	// High reads
		if (wr)
			data_out <= db_bus;
	end

// Write data holds for the whole write cycle, so no write row follows another
assert property (@(posedge clk) disable iff (!n_reset) !rw |-> !wr);

endmodule

// File: cpu_top.sv
`timescale 1ns/100ps

module cpu_top (
	input logic clk,
	input logic n_reset,
	input logic [7:0] data_in,
	output logic [15:0] addr,
	output logic rw,
	output logic [7:0] data_out
);

uop_pkg::alu_op_t alu_op;
uop_pkg::db_sel_t db_sel;
uop_pkg::ad_sel_t ad_sel;
uop_pkg::pc_op_t pc_op;
flag_pkg::flag_upd_t flag_upd;
logic a_load, sp_dec, ab_load, wr;
logic [7:0] dl, db_bus, alu_res, p;
logic [15:0] ad_bus;
logic alu_carry, alu_ovf, carry_in;

uop_sequencer u_seq (
	.clk(clk), .n_reset(n_reset), .dl(dl),
	.alu_op(alu_op), .db_sel(db_sel), .ad_sel(ad_sel), .pc_op(pc_op),
	.a_load(a_load), .sp_dec(sp_dec), .flag_upd(flag_upd),
	.ab_load(ab_load), .wr(wr)
);

cpu_datapath u_dp (
	.clk(clk), .n_reset(n_reset), .data_in(data_in),
	.alu_op(alu_op), .db_sel(db_sel), .ad_sel(ad_sel), .pc_op(pc_op),
	.a_load(a_load), .sp_dec(sp_dec), .carry_in(carry_in), .p(p),
	.dl(dl), .ad_bus(ad_bus), .db_bus(db_bus),
	.alu_res(alu_res), .alu_carry(alu_carry), .alu_ovf(alu_ovf)
);

status_unit u_status (
	.clk(clk), .n_reset(n_reset), .flag_upd(flag_upd),
	.alu_res(alu_res), .alu_carry(alu_carry), .alu_ovf(alu_ovf),
	.p(p), .carry_in(carry_in)
);

bus_interface u_bus (
	.clk(clk), .n_reset(n_reset), .ab_load(ab_load), .wr(wr),
	.ad_bus(ad_bus), .db_bus(db_bus),
	.addr(addr), .rw(rw), .data_out(data_out)
);

endmodule

// File: tb_memory.sv
`timescale 1ns/100ps

module tb_memory #(
	parameter int N_INSTR = 64
) (
	input logic clk,
	input logic n_reset,
	input logic [15:0] addr,
	input logic rw,
	input logic [7:0] wdata,
	output logic [7:0] rdata
);

logic [7:0] mem [0:65535];
logic [15:0] pc;

function automatic logic [31:0] xorshift(input logic [31:0] s);
	logic [31:0] x;
	x = s ^ (s << 13);
	x = x ^ (x >> 17);
	x = x ^ (x << 5);
	return x;
endfunction

// Places one instruction at pc and moves pc past it
task automatic place(input logic [7:0] op, input logic [7:0] b1, input logic [7:0] b2,
	input int len);
	mem[pc] = op;
	if (len > 1)
		mem[pc + 16'd1] = b1;
	if (len > 2)
		mem[pc + 16'd2] = b2;
	pc = pc + 16'(len);
endtask

initial begin
	logic [31:0] seed;
	logic [15:0] nxt;
	int i;
	seed = 32'hcd74_f083;
	for (i = 0; i < 65536; i++)
		mem[i] = i[15:8] ^ {i[6:0], i[7]} ^ 8'h5a;
	pc = 16'h0000;
	for (i = 0; i < N_INSTR; i++) begin
		seed = xorshift(seed);
		nxt = pc + 16'd3;
		case (seed[3:0])
		4'd0, 4'd1:	place(uop_pkg::OP_LDA_IMM, seed[15:8], 8'h00, 2);
		4'd2, 4'd3:	place(uop_pkg::OP_STA_ZP, {3'b111, seed[12:8]}, 8'h00, 2);	// Above the code
		4'd4, 4'd5, 4'd15:	place(uop_pkg::OP_ADC_IMM, seed[15:8], 8'h00, 2);
		4'd6, 4'd7:	place(uop_pkg::OP_SBC_IMM, seed[15:8], 8'h00, 2);
		4'd8:	place(uop_pkg::OP_SEC, 8'h00, 8'h00, 1);
		4'd9:	place(uop_pkg::OP_CLC, 8'h00, 8'h00, 1);
		4'd10, 4'd11:	place(uop_pkg::OP_PHP, 8'h00, 8'h00, 1);
		4'd12:	place(uop_pkg::OP_JMP_ABS, nxt[7:0], nxt[15:8], 3);	// Lands on the next one
		4'd13:	place(uop_pkg::OP_NOP, 8'h00, 8'h00, 1);
		default:	place(8'h02, 8'h00, 8'h00, 1);	// Unsupported opcode
		endcase
	end
	place(uop_pkg::OP_JMP_ABS, 8'h00, 8'h00, 3);
end

assign rdata = mem[addr];

always @(posedge clk)
	if (n_reset && rw == 1'b0)
		mem[addr] <= wdata;

endmodule

// File: mcpu_tb.sv
`timescale 1ns/100ps
`include "mcpu_cfg.svh"

module mcpu_tb;

localparam int N_INSTR = 64;
localparam int N_PASSES = 4;
localparam int TIMEOUT_CYCLES = (N_INSTR + 1) * 3 * N_PASSES + 100;

logic clk = 1'b0;
logic n_reset;
logic [7:0] data_in, data_out;
logic [15:0] addr;
logic rw;

// Reference model
logic [7:0] m_a, m_p, m_sp;
logic [15:0] m_pc;
logic [15:0] wr_addr;
logic [7:0] wr_data;
string wr_test;
int cycle, next_fetch, wr_cycle, passes;
int wd_count = 0;

cpu_top dut0 (
	.clk(clk), .n_reset(n_reset), .data_in(data_in),
	.addr(addr), .rw(rw), .data_out(data_out)
);

tb_memory #(.N_INSTR(N_INSTR)) mem0 (
	.clk(clk), .n_reset(n_reset), .addr(addr), .rw(rw),
	.wdata(data_out), .rdata(data_in)
);

initial begin
	forever #50 clk = ~clk;
end

task automatic end_in_failure();
	$display("Simulation finished: FAIL");
	$fatal(1, "Stopped at the first error");
endtask

task automatic show_problem(input string msg);
	$display("%s", msg);
	end_in_failure();
endtask

task automatic show_mismatch(input string name, input logic [15:0] exp, input logic [15:0] act);
	$display("error %s: expected %h, actual %h", name, exp, act);
	end_in_failure();
endtask

// One instruction per fetch
task automatic step_model();
	logic [7:0] op, b1, b2, opnd;
	int u_sum, s_sum;
	op = mem0.mem[m_pc];
	b1 = mem0.mem[m_pc + 16'd1];
	b2 = mem0.mem[m_pc + 16'd2];
	next_fetch = cycle + 2;
	case (op)
	uop_pkg::OP_LDA_IMM: begin
		m_a = b1;
		m_p[flag_pkg::FLAG_N] = b1[7];
		m_p[flag_pkg::FLAG_Z] = b1 == 8'h00;
		m_pc = m_pc + 16'd2;
	end
	uop_pkg::OP_ADC_IMM, uop_pkg::OP_SBC_IMM: begin
		opnd = (op == uop_pkg::OP_SBC_IMM) ? ~b1 : b1;
		u_sum = int'(m_a) + int'(opnd) + int'(m_p[flag_pkg::FLAG_C]);
		s_sum = int'($signed(m_a)) + int'($signed(opnd)) + int'(m_p[flag_pkg::FLAG_C]);
		m_p[flag_pkg::FLAG_V] = (s_sum > 127) || (s_sum < -128);	// Signed result out of range
		m_p[flag_pkg::FLAG_N] = u_sum[7];
		m_p[flag_pkg::FLAG_Z] = u_sum[7:0] == 8'h00;
		m_p[flag_pkg::FLAG_C] = u_sum > 255;
		m_a = u_sum[7:0];
		m_pc = m_pc + 16'd2;
	end
	uop_pkg::OP_SEC, uop_pkg::OP_CLC: begin
		m_p[flag_pkg::FLAG_C] = op == uop_pkg::OP_SEC;
		m_pc = m_pc + 16'd1;
	end
	uop_pkg::OP_STA_ZP: begin
		wr_test = "sta";
		wr_cycle = cycle + 2;
		wr_addr = {8'h00, b1};
		wr_data = m_a;
		next_fetch = cycle + 3;
		m_pc = m_pc + 16'd2;
	end
	uop_pkg::OP_PHP: begin
		wr_test = "php";
		wr_cycle = cycle + 2;
		wr_addr = {`MCPU_STACK_PAGE, m_sp};
		wr_data = m_p | 8'h30;	// R and B read as one in the pushed byte
		m_sp = m_sp - 8'd1;
		next_fetch = cycle + 3;
		m_pc = m_pc + 16'd1;
	end
	uop_pkg::OP_JMP_ABS: begin
		m_pc = {b2, b1};
		next_fetch = cycle + 3;
	end
	default:	m_pc = m_pc + 16'd1;
	endcase
endtask

task automatic check_cycle();
	if (cycle == next_fetch) begin
		assert (rw) else show_problem("A fetch cycle drove a write instead of a read");
		assert (addr == m_pc) else show_mismatch("fetch_addr", m_pc, addr);
		if (m_pc == 16'h0000 && cycle != 1)
			passes++;	// Program looped back through the final JMP
		step_model();
	end
	if (cycle == wr_cycle) begin
		assert (!rw) else show_problem({"The ", wr_test, " store cycle did not write memory"});
		assert (addr == wr_addr) else show_mismatch({wr_test, "_addr"}, wr_addr, addr);
		assert (data_out == wr_data)
			else show_mismatch({wr_test, "_data"}, {8'h00, wr_data}, {8'h00, data_out});
	end else begin
		assert (rw) else show_problem("Memory was written outside an STA or PHP store cycle");
	end
endtask

always @(posedge clk) begin
	wd_count++;
	if (wd_count > TIMEOUT_CYCLES)
		show_problem("Timeout, the program passes did not finish within the cycle limit");
end

initial begin
	n_reset = 1'b0;
	m_a = 8'h00;
	m_p = 8'h20;	// Only R after reset
	m_sp = `MCPU_SP_RESET;
	m_pc = 16'h0000;
	wr_test = "none";
	wr_cycle = 0;
	passes = 0;
	cycle = 1;
	next_fetch = 1;
	repeat (2) @(negedge clk);
	n_reset = 1'b1;
	while (passes < N_PASSES) begin
		check_cycle();
		@(negedge clk);
		cycle++;
	end
	$display("Simulation finished: PASS");
	$finish;
end

endmodule

// File: mcpu.f
+incdir+.
uop_pkg.sv
flag_pkg.sv
uop_sequencer.sv
cpu_datapath.sv
status_unit.sv
bus_interface.sv
cpu_top.sv
tb_memory.sv
mcpu_tb.sv

// File: run_sim.sh
#!/bin/bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module mcpu_tb -f mcpu.f \
	-o mcpu_sim > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/mcpu_sim > sim.log 2>&1
cat sim.log
grep -q "Simulation finished: FAIL" sim.log && { echo "Result: fail"; exit 1; } || echo "Result: pass"
